// ==== source/stbuf_pkg.sv ====
/*
 * Shared sizes, size codes and the data word type of the store buffer.
 * Modules import it inside their bodies and use scoped names in port lists.
 */
package stbuf_pkg;

   // ------------------------------------------------------------------
   // buffer and word geometry
   // ------------------------------------------------------------------
   localparam int STBUF_DEPTH    = 8;
   localparam int PTR_WIDTH      = $clog2(STBUF_DEPTH);
   localparam int ADDR_WIDTH     = 16;
   localparam int DATA_WIDTH     = 32;
   localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
   localparam int OFFSET_WIDTH   = $clog2(BYTES_PER_WORD);   // word compare uses bits above

   // store size codes
   localparam int SIZE_WIDTH = 2;
   localparam logic [SIZE_WIDTH-1:0] SIZE_BYTE = 2'd0;
   localparam logic [SIZE_WIDTH-1:0] SIZE_HALF = 2'd1;
   localparam logic [SIZE_WIDTH-1:0] SIZE_WORD = 2'd2;

   // two slots kept back for stores that are still in dc3/dc4
   localparam int FULL_LEVEL = STBUF_DEPTH - 2;

   // ------------------------------------------------------------------
   // data word, drained whole and merged byte by byte
   // ------------------------------------------------------------------
   typedef union packed {
      logic [DATA_WIDTH-1:0]          word;
      logic [BYTES_PER_WORD-1:0][7:0] bytes;
   } data_word_u;

   // byte lanes touched by an aligned store
   function automatic logic [BYTES_PER_WORD-1:0] store_byteen(
      input logic [SIZE_WIDTH-1:0]   size,
      input logic [OFFSET_WIDTH-1:0] offset
   );
      logic [BYTES_PER_WORD-1:0] base;
      case (size)
         SIZE_BYTE: base = 4'b0001;
         SIZE_HALF: base = 4'b0011;
         SIZE_WORD: base = 4'b1111;
         default:   base = 4'b0000;   // reserved code writes nothing
      endcase
      return base << offset;
   endfunction

endpackage

// ==== source/store_pipe.sv ====
/*
 * dc3/dc4 store stages ahead of the buffer. Feeds the buffer write from dc4,
 * counts stores in flight and reports per-stage hits for a load address.
 */
`timescale 1ns/1ps

module store_pipe (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    st_valid,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        st_addr,
   input  logic [stbuf_pkg::SIZE_WIDTH-1:0]        st_size,
   input  stbuf_pkg::data_word_u                   st_data,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        ld_addr,
   output logic                                    wr_valid,
   output logic [stbuf_pkg::ADDR_WIDTH-1:0]        wr_addr,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    wr_byteen,
   output stbuf_pkg::data_word_u                   wr_data,
   output logic [1:0]                              pipe_count,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    dc3_hit_byteen,
   output stbuf_pkg::data_word_u                   dc3_hit_data,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    dc4_hit_byteen,
   output stbuf_pkg::data_word_u                   dc4_hit_data
);
   import stbuf_pkg::*;

   logic                      dc3_valid, dc4_valid;
   logic [ADDR_WIDTH-1:0]     dc3_addr, dc4_addr;
   logic [SIZE_WIDTH-1:0]     dc3_size;
   logic [BYTES_PER_WORD-1:0] dc3_byteen, dc4_byteen;
   data_word_u                dc3_data, dc4_data;
   logic                      dc3_word_hit, dc4_word_hit;

   // ------------------------------------------------------------------
   // stage registers
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dc3_valid <= 1'b0;
         dc4_valid <= 1'b0;
      end else begin
         dc3_valid <= st_valid;
         dc4_valid <= dc3_valid;
      end
   end

   always_ff @(posedge clk) begin
      dc3_addr   <= st_addr;
      dc3_size   <= st_size;
      dc3_data   <= st_data;
      dc4_addr   <= dc3_addr;
      dc4_byteen <= dc3_byteen;   // enables are resolved once, in dc3
      dc4_data   <= dc3_data;
   end

   assign dc3_byteen = store_byteen(dc3_size, dc3_addr[OFFSET_WIDTH-1:0]);

   // dc4 is the buffer write port
   assign wr_valid   = dc4_valid;
   assign wr_addr    = dc4_addr;
   assign wr_byteen  = dc4_byteen;
   assign wr_data    = dc4_data;
   assign pipe_count = {1'b0, dc3_valid} + {1'b0, dc4_valid};

   // ------------------------------------------------------------------
   // load lookup against both stages
   // ------------------------------------------------------------------
   assign dc3_word_hit = dc3_valid &&
                         (dc3_addr[ADDR_WIDTH-1:OFFSET_WIDTH] == ld_addr[ADDR_WIDTH-1:OFFSET_WIDTH]);
   assign dc4_word_hit = dc4_valid &&
                         (dc4_addr[ADDR_WIDTH-1:OFFSET_WIDTH] == ld_addr[ADDR_WIDTH-1:OFFSET_WIDTH]);

   assign dc3_hit_byteen = dc3_word_hit ? dc3_byteen : '0;
   assign dc4_hit_byteen = dc4_word_hit ? dc4_byteen : '0;

   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         dc3_hit_data.bytes[b] = dc3_hit_byteen[b] ? dc3_data.bytes[b] : 8'h00;
         dc4_hit_data.bytes[b] = dc4_hit_byteen[b] ? dc4_data.bytes[b] : 8'h00;
      end
   end

endmodule

// ==== source/store_queue.sv ====
/*
 * Eight-entry coalescing store buffer. Allocates or merges the dc4 write,
 * drains the oldest entry per commit and looks up a load's word address.
 */
`timescale 1ns/1ps

module store_queue (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    wr_valid,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        wr_addr,
   input  logic [stbuf_pkg::BYTES_PER_WORD-1:0]    wr_byteen,
   input  stbuf_pkg::data_word_u                   wr_data,
   input  logic                                    commit,
   input  logic [1:0]                              pipe_count,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        ld_addr,
   output logic                                    stbuf_reqvld,
   output logic [stbuf_pkg::ADDR_WIDTH-1:0]        stbuf_addr,
   output stbuf_pkg::data_word_u                   stbuf_data,
   output logic                                    stbuf_empty,
   output logic                                    stbuf_full,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    q_hit_byteen,
   output stbuf_pkg::data_word_u                   q_hit_data
);
   import stbuf_pkg::*;

   // entry fields
   logic [STBUF_DEPTH-1:0]                     ent_valid;
   logic [STBUF_DEPTH-1:0][ADDR_WIDTH-1:0]     ent_addr;
   logic [STBUF_DEPTH-1:0][BYTES_PER_WORD-1:0] ent_byteen;
   data_word_u                                 ent_data [STBUF_DEPTH];

   logic [PTR_WIDTH-1:0]   wr_ptr, rd_ptr;
   logic [STBUF_DEPTH-1:0] wr_match;        // valid entry of the same word, not popping
   logic [STBUF_DEPTH-1:0] alloc_en, merge_en;
   logic                   coalesce;
   logic [STBUF_DEPTH-1:0] ld_match;
   logic [PTR_WIDTH:0]     num_valid;
   logic [PTR_WIDTH:0]     occupancy;

   // ------------------------------------------------------------------
   // write: coalesce or allocate
   // ------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         wr_match[i] = ent_valid[i] &&
                       (ent_addr[i][ADDR_WIDTH-1:OFFSET_WIDTH] ==
                        wr_addr[ADDR_WIDTH-1:OFFSET_WIDTH]) &&
                       !(commit && (rd_ptr == PTR_WIDTH'(i)));
      end
   end

   assign coalesce = |wr_match;

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         alloc_en[i] = wr_valid && !coalesce && (wr_ptr == PTR_WIDTH'(i));
         merge_en[i] = wr_valid && wr_match[i];
      end
   end

   // valid bits and pointers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ent_valid <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
      end else begin
         if (commit) begin
            ent_valid[rd_ptr] <= 1'b0;
            rd_ptr            <= rd_ptr + 1'b1;   // depth is a power of two
         end
         if (wr_valid && !coalesce) begin
            ent_valid[wr_ptr] <= 1'b1;
            wr_ptr            <= wr_ptr + 1'b1;
         end
      end
   end

   // entry payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (alloc_en[i]) begin
            ent_addr[i]   <= wr_addr;
            ent_byteen[i] <= wr_byteen;
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               ent_data[i].bytes[b] <= wr_byteen[b] ? wr_data.bytes[b] : 8'h00;
            end
         end else if (merge_en[i]) begin
            ent_byteen[i] <= ent_byteen[i] | wr_byteen;
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               if (wr_byteen[b]) begin
                  ent_data[i].bytes[b] <= wr_data.bytes[b];   // newest byte wins
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------
   // drain and flags
   // ------------------------------------------------------------------
   assign stbuf_reqvld = ent_valid[rd_ptr];
   assign stbuf_addr   = ent_addr[rd_ptr];
   assign stbuf_data   = ent_data[rd_ptr];

   always_comb begin
      num_valid = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         num_valid = num_valid + {{PTR_WIDTH{1'b0}}, ent_valid[i]};
      end
   end

   assign occupancy   = num_valid + {{(PTR_WIDTH-1){1'b0}}, pipe_count};  // in-flight stores count
   assign stbuf_full  = (occupancy >= FULL_LEVEL);
   assign stbuf_empty = (num_valid == '0);

   // ------------------------------------------------------------------
   // load lookup, at most one entry per word
   // ------------------------------------------------------------------
   always_comb begin
      q_hit_byteen    = '0;
      q_hit_data.word = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         ld_match[i] = ent_valid[i] &&
                       (ent_addr[i][ADDR_WIDTH-1:OFFSET_WIDTH] ==
                        ld_addr[ADDR_WIDTH-1:OFFSET_WIDTH]);
         q_hit_byteen    = q_hit_byteen | ({BYTES_PER_WORD{ld_match[i]}} & ent_byteen[i]);
         q_hit_data.word = q_hit_data.word | ({DATA_WIDTH{ld_match[i]}} & ent_data[i].word);
      end
   end

endmodule

// ==== source/fwd_merge.sv ====
/*
 * Merges the three forwarding sources per byte, youngest first, and
 * registers the result on each load strobe.
 */
`timescale 1ns/1ps

module fwd_merge (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    ld_valid,
   input  logic [stbuf_pkg::BYTES_PER_WORD-1:0]    dc3_hit_byteen,
   input  stbuf_pkg::data_word_u                   dc3_hit_data,
   input  logic [stbuf_pkg::BYTES_PER_WORD-1:0]    dc4_hit_byteen,
   input  stbuf_pkg::data_word_u                   dc4_hit_data,
   input  logic [stbuf_pkg::BYTES_PER_WORD-1:0]    q_hit_byteen,
   input  stbuf_pkg::data_word_u                   q_hit_data,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    fwd_byteen_dc3,
   output stbuf_pkg::data_word_u                   fwd_data_dc3
);
   import stbuf_pkg::*;

   logic [BYTES_PER_WORD-1:0] merge_byteen;
   data_word_u                merge_data;

   assign merge_byteen = dc3_hit_byteen | dc4_hit_byteen | q_hit_byteen;

   // dc3 > dc4 > buffer in each lane
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         if (dc3_hit_byteen[b]) begin
            merge_data.bytes[b] = dc3_hit_data.bytes[b];
         end else if (dc4_hit_byteen[b]) begin
            merge_data.bytes[b] = dc4_hit_data.bytes[b];
         end else begin
            merge_data.bytes[b] = q_hit_data.bytes[b];   // zero when the buffer misses
         end
      end
   end

   // result holds until the next load
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fwd_byteen_dc3 <= '0;
      end else if (ld_valid) begin
         fwd_byteen_dc3 <= merge_byteen;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_valid) fwd_data_dc3 <= merge_data;
   end

endmodule

// ==== source/lsu_stbuf.sv ====
/*
 * Store buffer top. Store pipe and buffer are looked up side by side and
 * their hits meet in the forwarding merger.
 */
`timescale 1ns/1ps

module lsu_stbuf (
   input  logic                                    clk,
   input  logic                                    rst_n,
   // store strobe
   input  logic                                    st_valid,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        st_addr,
   input  logic [stbuf_pkg::SIZE_WIDTH-1:0]        st_size,
   input  stbuf_pkg::data_word_u                   st_data,
   // drain
   input  logic                                    commit,
   output logic                                    stbuf_reqvld,
   output logic [stbuf_pkg::ADDR_WIDTH-1:0]        stbuf_addr,
   output stbuf_pkg::data_word_u                   stbuf_data,
   output logic                                    stbuf_empty,
   output logic                                    stbuf_full,
   // load forwarding
   input  logic                                    ld_valid,
   input  logic [stbuf_pkg::ADDR_WIDTH-1:0]        ld_addr,
   output logic [stbuf_pkg::BYTES_PER_WORD-1:0]    fwd_byteen_dc3,
   output stbuf_pkg::data_word_u                   fwd_data_dc3
);
   import stbuf_pkg::*;

   // ------------------------------------------------------------------
   // internal nets
   // ------------------------------------------------------------------
   logic                      wr_valid;
   logic [ADDR_WIDTH-1:0]     wr_addr;
   logic [BYTES_PER_WORD-1:0] wr_byteen;
   data_word_u                wr_data;
   logic [1:0]                pipe_count;
   logic [BYTES_PER_WORD-1:0] dc3_hit_byteen, dc4_hit_byteen, q_hit_byteen;
   data_word_u                dc3_hit_data, dc4_hit_data, q_hit_data;

   store_pipe u_store_pipe (
      .clk, .rst_n,
      .st_valid, .st_addr, .st_size, .st_data,
      .ld_addr,
      .wr_valid, .wr_addr, .wr_byteen, .wr_data,
      .pipe_count,
      .dc3_hit_byteen, .dc3_hit_data,
      .dc4_hit_byteen, .dc4_hit_data
   );

   store_queue u_store_queue (
      .clk, .rst_n,
      .wr_valid, .wr_addr, .wr_byteen, .wr_data,
      .commit, .pipe_count, .ld_addr,
      .stbuf_reqvld, .stbuf_addr, .stbuf_data,
      .stbuf_empty, .stbuf_full,
      .q_hit_byteen, .q_hit_data
   );

   fwd_merge u_fwd_merge (
      .clk, .rst_n, .ld_valid,
      .dc3_hit_byteen, .dc3_hit_data,
      .dc4_hit_byteen, .dc4_hit_data,
      .q_hit_byteen, .q_hit_data,
      .fwd_byteen_dc3, .fwd_data_dc3
   );

endmodule

// ==== tb/lsu_stbuf_properties.sv ====
/*
 * Interface rules of the store buffer, bound into the top level.
 */
`timescale 1ns/1ps

module lsu_stbuf_properties (
   input logic clk,
   input logic rst_n,
   input logic st_valid,
   input logic commit,
   input logic stbuf_reqvld,
   input logic stbuf_empty,
   input logic stbuf_full
);

   // a pop needs an entry at the read pointer
   commit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
      commit |-> stbuf_reqvld)
      else $error("commit while no entry is ready");

   // entries stay contiguous from the read pointer, so reqvld tracks a non-empty buffer
   reqvld_tracks_empty: assert property (@(posedge clk) disable iff (!rst_n)
      stbuf_reqvld == !stbuf_empty)
      else $error("reqvld does not match the empty flag");

   no_store_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      stbuf_full |-> !st_valid)
      else $error("store strobed while full");

endmodule

bind lsu_stbuf lsu_stbuf_properties u_props (.*);

// ==== tb/stbuf_checker.sv ====
/*
 * Reference model of the store pipe, buffer and forwarding. Watches the DUT
 * ports and compares every output on each rising edge.
 */
`timescale 1ns/1ps

module stbuf_checker (
   input logic        clk,
   input logic        rst_n,
   input logic        st_valid,
   input logic [15:0] st_addr,
   input logic [1:0]  st_size,
   input logic [31:0] st_data,
   input logic        commit,
   input logic        ld_valid,
   input logic [15:0] ld_addr,
   input logic        stbuf_reqvld,
   input logic [15:0] stbuf_addr,
   input logic [31:0] stbuf_data,
   input logic        stbuf_empty,
   input logic        stbuf_full,
   input logic [3:0]  fwd_byteen_dc3,
   input logic [31:0] fwd_data_dc3
);
   import stbuf_pkg::*;

   int err_count = 0;
   int alloc_count = 0;
   int pop_count = 0;

   // model state
   logic        p3_v, p4_v;
   logic [15:0] p3_addr, p4_addr;
   logic [3:0]  p3_be, p4_be;
   logic [31:0] p3_data, p4_data;
   logic        m_valid [8];
   logic [15:0] m_addr [8];
   logic [3:0]  m_be [8];
   logic [31:0] m_data [8];
   int          m_wr, m_rd;
   logic [3:0]  m_fwd_be;
   logic [31:0] m_fwd_data;

   function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] off);
      logic [3:0] m;
      m = (size == 2'd0) ? 4'h1 : (size == 2'd1) ? 4'h3 : (size == 2'd2) ? 4'hf : 4'h0;
      return m << off;
   endfunction

   task automatic report(input string msg);
      err_count++;
      $display("ERR t=%0t %s", $time, msg);
   endtask

   always @(posedge clk) begin : model_step
      int cnt;
      int hit;
      logic [3:0]  lbe;
      logic [31:0] ldat;
      if (!rst_n) begin
         p3_v = 0;
         p4_v = 0;
         m_wr = 0;
         m_rd = 0;
         m_fwd_be = '0;
         for (int i = 0; i < 8; i++) m_valid[i] = 0;
      end else begin
         // ---------------------------------------------------------------
         // compare outputs against the state before this edge
         // ---------------------------------------------------------------
         cnt = 0;
         for (int i = 0; i < 8; i++) cnt += int'(m_valid[i]);
         if (stbuf_reqvld !== m_valid[m_rd])
            report($sformatf("reqvld %b, expected %b", stbuf_reqvld, m_valid[m_rd]));
         else if (m_valid[m_rd] && (stbuf_addr !== m_addr[m_rd] || stbuf_data !== m_data[m_rd]))
            report($sformatf("drain %h/%h, expected %h/%h", stbuf_addr, stbuf_data,
                             m_addr[m_rd], m_data[m_rd]));
         if (stbuf_empty !== (cnt == 0))
            report($sformatf("empty %b with %0d entries", stbuf_empty, cnt));
         if (stbuf_full !== ((cnt + int'(p3_v) + int'(p4_v)) >= FULL_LEVEL))
            report($sformatf("full %b with %0d entries", stbuf_full, cnt));
         if (fwd_byteen_dc3 !== m_fwd_be)
            report($sformatf("fwd byteen %h, expected %h", fwd_byteen_dc3, m_fwd_be));
         for (int b = 0; b < 4; b++) begin
            if (m_fwd_be[b] && fwd_data_dc3[8*b +: 8] !== m_fwd_data[8*b +: 8])
               report($sformatf("fwd byte %0d is %h, expected %h", b,
                                fwd_data_dc3[8*b +: 8], m_fwd_data[8*b +: 8]));
         end
         // forwarding lookup, buffer first so younger sources overwrite
         if (ld_valid) begin
            lbe = '0;
            ldat = '0;
            for (int i = 0; i < 8; i++) begin
               if (m_valid[i] && m_addr[i][15:2] == ld_addr[15:2]) begin
                  lbe = m_be[i];
                  ldat = m_data[i];
               end
            end
            for (int b = 0; b < 4; b++) begin
               if (p4_v && p4_addr[15:2] == ld_addr[15:2] && p4_be[b])
                  ldat[8*b +: 8] = p4_data[8*b +: 8];
               if (p3_v && p3_addr[15:2] == ld_addr[15:2] && p3_be[b])
                  ldat[8*b +: 8] = p3_data[8*b +: 8];
            end
            m_fwd_be = lbe | (p4_v && p4_addr[15:2] == ld_addr[15:2] ? p4_be : 4'h0)
                           | (p3_v && p3_addr[15:2] == ld_addr[15:2] ? p3_be : 4'h0);
            m_fwd_data = ldat;
         end
         if (commit) begin   // pop first, the popped entry takes no merge
            m_valid[m_rd] = 0;
            m_rd = (m_rd + 1) % 8;
            pop_count++;
         end
         if (p4_v) begin
            hit = -1;
            for (int i = 0; i < 8; i++)
               if (m_valid[i] && m_addr[i][15:2] == p4_addr[15:2]) hit = i;
            if (hit < 0) begin
               m_valid[m_wr] = 1;
               m_addr[m_wr] = p4_addr;
               m_be[m_wr] = p4_be;
               m_data[m_wr] = '0;
               hit = m_wr;
               m_wr = (m_wr + 1) % 8;
               alloc_count++;
            end
            m_be[hit] = m_be[hit] | p4_be;
            for (int b = 0; b < 4; b++)
               if (p4_be[b]) m_data[hit][8*b +: 8] = p4_data[8*b +: 8];
         end
         p4_v = p3_v;
         p4_addr = p3_addr;
         p4_be = p3_be;
         p4_data = p3_data;
         p3_v = st_valid;
         p3_addr = st_addr;
         p3_be = lane_mask(st_size, st_addr[1:0]);
         p3_data = st_data;
      end
   end

endmodule

// ==== tb/lsu_stbuf_tb.sv ====
/*
 * Store buffer testbench. Runs LFSR driven test phases against lsu_stbuf,
 * with stbuf_checker doing the comparing.
 */
`timescale 1ns/1ps

module lsu_stbuf_tb;
   import stbuf_pkg::*;

   logic clk, rst_n, st_valid, commit, ld_valid;
   logic [15:0] st_addr, ld_addr;
   logic [1:0]  st_size;
   data_word_u  st_data, stbuf_data, fwd_data_dc3;
   logic stbuf_reqvld, stbuf_empty, stbuf_full;
   logic [15:0] stbuf_addr;
   logic [3:0]  fwd_byteen_dc3;
   logic [15:0] lfsr = 16'd64003;
   int   n_pass = 0, n_fail = 0;
   logic hung = 0;
   string hang_reason;

   lsu_stbuf uut (.*);
   stbuf_checker chk (.*, .st_data(st_data.word), .stbuf_data(stbuf_data.word),
                      .fwd_data_dc3(fwd_data_dc3.word));

   initial begin
      clk = 0;
      forever #2 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // one test phase of stores with optional loads and commits, then a full drain
   task automatic run_phase(input string name, input int n_ops, input logic [3:0] wmask,
                            input logic loads, input logic commits, input logic burst,
                            input logic need_full);
      logic [31:0] r, sz, off, w;
      int errs0, pops0, allocs0, t;
      logic full_seen;
      errs0 = chk.err_count;
      pops0 = chk.pop_count;
      allocs0 = chk.alloc_count;
      full_seen = 0;
      for (int i = 0; i < n_ops + 8; i++) begin
         @(posedge clk);
         full_seen |= stbuf_full;
         draw(4, w);
         draw(2, sz);
         draw(2, off);
         draw(32, r);
         if (sz == 3) sz = 2;
         off = (sz == 0) ? off : (sz == 1) ? (off & 2) : 0;
         st_valid <= (i < n_ops) && !stbuf_full;
         st_addr  <= 16'h0400 + 16'((w & 32'(wmask)) << 2) + 16'(off);
         st_size  <= sz[1:0];
         st_data  <= r;
         draw(1, r);
         commit   <= commits && stbuf_reqvld && r[0];
         draw(4, w);
         ld_valid <= loads || (i >= n_ops);   // trailing loads see the buffer alone
         ld_addr  <= 16'h0400 + 16'((w & 32'(wmask)) << 2) + 16'(w[1:0]);
         @(posedge clk);
         draw(32, r);
         // back-to-back store to the same address fills dc3 and dc4 together
         st_valid <= burst && (i < n_ops) && !stbuf_full;
         st_data  <= r;
         commit   <= 0;
         ld_valid <= 0;
      end
      if (need_full && !full_seen) begin
         $display("ERR t=%0t %s: full never rose", $time, name);
         chk.err_count++;
      end
      t = 0;
      while (!stbuf_empty && t < 200) begin   // drain with a commit every other cycle
         @(posedge clk);
         commit <= stbuf_reqvld;
         @(posedge clk);
         commit <= 0;
         t++;
      end
      if (!stbuf_empty) begin
         hung = 1;
         hang_reason = {"buffer never drained in test ", name};
      end else if (chk.pop_count - pops0 != chk.alloc_count - allocs0) begin
         $display("ERR t=%0t %s: %0d pops for %0d allocations", $time, name,
                  chk.pop_count - pops0, chk.alloc_count - allocs0);
         chk.err_count++;
      end
      if (chk.err_count == errs0) n_pass++;
      else n_fail++;
      $display("test %s: %0d errors", name, chk.err_count - errs0);
   endtask

   initial begin
      rst_n = 0;
      st_valid = 0;
      st_addr = '0;
      st_size = '0;
      st_data = '0;
      commit = 0;
      ld_valid = 0;
      ld_addr = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1;
      @(posedge clk);
      @(negedge clk);
      if (stbuf_reqvld || stbuf_full || !stbuf_empty || fwd_byteen_dc3 != 0) begin
         $display("ERR t=%0t reset state wrong", $time);
         chk.err_count++;
         n_fail++;
      end else n_pass++;
      $display("test reset: done");
      if (!hung) run_phase("drain", 6, 4'h3, 0, 0, 0, 0);
      if (!hung) run_phase("coalesce", 12, 4'h1, 0, 0, 0, 0);
      if (!hung) run_phase("buffer_fwd", 8, 4'h3, 0, 0, 0, 0);
      if (!hung) run_phase("pipe_priority", 40, 4'h1, 1, 1, 1, 0);
      if (!hung) run_phase("backpressure", 20, 4'hf, 1, 0, 0, 1);
      $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, chk.err_count);
      if (hung || n_fail != 0 || chk.err_count != 0) begin
         if (hung) $display("timeout: %s", hang_reason);
         $display("Testbench failed");
      end else begin
         $display("Testbench passed");
      end
      $finish;
   end

endmodule

// ==== lsu_stbuf.f ====
source/stbuf_pkg.sv
source/store_pipe.sv
source/store_queue.sv
source/fwd_merge.sv
source/lsu_stbuf.sv
tb/lsu_stbuf_properties.sv
tb/stbuf_checker.sv
tb/lsu_stbuf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_stbuf_tb
FILELIST  ?= lsu_stbuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
